//--- rename_params.svh
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Datapath width
`define RN_DATA_W 32

// Architectural register index, 8 registers
`define RN_AREG_W 3

// Free list and active list index, 4 slots
`define RN_FREE_W 2

// Physical register index
// Covers the architectural set plus one free-list depth
`define RN_PREG_W (`RN_AREG_W + 1)

// Immediate field carried by each instruction
`define RN_IMM_W 16

`endif

//--- rename_pkg.sv
`include "rename_params.svh"

package rename_pkg;

    //////////////////////////////
    // Operation codes
    //////////////////////////////

    typedef enum logic [1:0]
    {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_XOR = 2'd2,
        OP_LDI = 2'd3
    } opcode_e;

    //////////////////////////////
    // Stage FSM states
    //////////////////////////////

    typedef enum logic
    {
        ISSUE_IDLE = 1'b0,
        ISSUE_REQ  = 1'b1
    } issue_state_e;

    typedef enum logic [1:0]
    {
        EX_IDLE  = 2'd0,
        EX_EXEC  = 2'd1,
        EX_WRITE = 2'd2
    } exec_state_e;

    // Decoded instruction as seen by the rename unit
    typedef struct packed
    {
        opcode_e                op;
        logic [`RN_AREG_W-1:0]  rd;
        logic [`RN_AREG_W-1:0]  rs;
        logic [`RN_AREG_W-1:0]  rt;
        logic [`RN_IMM_W-1:0]   imm;
    } rename_req_t;

endpackage

//--- rename_ifs.sv
`include "rename_params.svh"

// Issue stage to rename unit, Wishbone classic
interface rename_if;
    logic                    cyc;
    logic                    stb;
    rename_pkg::rename_req_t req;
    logic                    ack;

    modport master (output cyc, output stb, output req, input ack);
    modport slave  (input cyc, input stb, input req, output ack);
endinterface

// Rename unit to execute stage, operands already read
interface exec_if;
    logic                  cyc;
    logic                  stb;
    rename_pkg::opcode_e   op;
    logic [`RN_AREG_W-1:0] arch_rd;
    logic [`RN_PREG_W-1:0] dest_preg;
    logic [`RN_FREE_W-1:0] slot;
    logic [`RN_DATA_W-1:0] a_data;
    logic [`RN_DATA_W-1:0] b_data;
    logic                  ack;

    modport master (output cyc, output stb, output op, output arch_rd, output dest_preg,
                    output slot, output a_data, output b_data, input ack);
    modport slave  (input cyc, input stb, input op, input arch_rd, input dest_preg,
                    input slot, input a_data, input b_data, output ack);
endinterface

// Execute stage back to the rename unit
interface writeback_if;
    logic                  cyc;
    logic                  stb;
    logic [`RN_PREG_W-1:0] preg;
    logic [`RN_FREE_W-1:0] slot;
    logic [`RN_DATA_W-1:0] data;
    logic                  ack;

    modport master (output cyc, output stb, output preg, output slot, output data, input ack);
    modport slave  (input cyc, input stb, input preg, input slot, input data, output ack);
endinterface

//--- issue_stage.sv
module issue_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    output logic                    instr_ready,
    input  rename_pkg::rename_req_t instr,
    rename_if.master                rn
);

    rename_pkg::issue_state_e state;
    logic                     take;

    assign take = instr_valid && instr_ready;

    //////////////////////////////
    // Request FSM
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= rename_pkg::ISSUE_IDLE;
            instr_ready <= 1'b0;
            rn.cyc      <= 1'b0;
            rn.stb      <= 1'b0;
        end
        else
        begin
            case (state)
                rename_pkg::ISSUE_IDLE:
                begin
                    if (take)
                    begin
                        state       <= rename_pkg::ISSUE_REQ;
                        instr_ready <= 1'b0;
                        rn.cyc      <= 1'b1;
                        rn.stb      <= 1'b1;
                    end
                    else
                    begin
                        instr_ready <= 1'b1;
                    end
                end
                rename_pkg::ISSUE_REQ:
                begin
                    // Ack may take many cycles when the rename unit stalls
                    if (rn.ack)
                    begin
                        state       <= rename_pkg::ISSUE_IDLE;
                        instr_ready <= 1'b1;
                        rn.cyc      <= 1'b0;
                        rn.stb      <= 1'b0;
                    end
                end
                default:
                begin
                    state <= rename_pkg::ISSUE_IDLE;
                end
            endcase
        end
    end

    // Latched instruction, rd 0 passes through unchanged
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            rn.req <= instr;
        end
    end

    // Request held steady across rename back-pressure
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        rn.stb && !rn.ack |=> $stable(rn.req)
    ) else $error("rename request changed before ack");

endmodule

//--- rename_unit.sv
`include "rename_params.svh"

module rename_unit (
    input  logic                clk,
    input  logic                rst_n,
    rename_if.slave             rn,
    exec_if.master              ex,
    writeback_if.slave          wb,
    output logic [`RN_FREE_W:0] free_count
);

    localparam int NAREG = 1 << `RN_AREG_W;
    localparam int NFREE = 1 << `RN_FREE_W;
    localparam int NPREG = NAREG + NFREE;

    logic [`RN_PREG_W-1:0] map_table [NAREG];
    logic [`RN_PREG_W-1:0] free_list [NFREE];
    logic [`RN_FREE_W-1:0] fl_head;
    logic [`RN_FREE_W-1:0] fl_tail;
    logic [`RN_FREE_W:0]   fl_count;
    logic [`RN_PREG_W-1:0] al_old [NFREE];
    logic [NFREE-1:0]      al_done;
    logic [`RN_FREE_W-1:0] al_head;
    logic [`RN_FREE_W-1:0] al_tail;
    logic [`RN_DATA_W-1:0] preg [NPREG];
    logic [NPREG-1:0]      preg_ready;

    logic [`RN_PREG_W-1:0] rs_preg;
    logic [`RN_PREG_W-1:0] rt_preg;
    logic [`RN_DATA_W-1:0] imm_ext;
    logic                  need_dest;
    logic                  accept;
    logic                  alloc;
    logic                  retire;
    logic                  wb_write;

    //////////////////////////////
    // Lookup and stall decision
    //////////////////////////////

    assign rs_preg   = map_table[rn.req.rs];
    assign rt_preg   = map_table[rn.req.rt];
    assign imm_ext   = {{(`RN_DATA_W - `RN_IMM_W){1'b0}}, rn.req.imm};
    assign need_dest = rn.req.rd != '0;

    // Wait for a free register, ready sources and an idle execute stage
    assign accept = rn.cyc && rn.stb && !rn.ack && !ex.cyc
                    && (!need_dest || fl_count != '0)
                    && preg_ready[rs_preg] && preg_ready[rt_preg];

    assign alloc      = accept && need_dest;
    assign retire     = al_done[al_head];
    assign wb_write   = wb.cyc && wb.stb && !wb.ack;
    assign free_count = fl_count;

    // Handshakes
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rn.ack <= 1'b0;
            wb.ack <= 1'b0;
            ex.cyc <= 1'b0;
            ex.stb <= 1'b0;
        end
        else
        begin
            rn.ack <= accept;
            wb.ack <= wb_write;
            if (accept)
            begin
                ex.cyc <= 1'b1;
                ex.stb <= 1'b1;
            end
            else if (ex.ack)
            begin
                ex.cyc <= 1'b0;
                ex.stb <= 1'b0;
            end
        end
    end

    // Operands to the execute stage, old mapping into the active list
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            ex.op        <= rn.req.op;
            ex.arch_rd   <= rn.req.rd;
            ex.dest_preg <= need_dest ? free_list[fl_head] : '0;
            ex.slot      <= al_tail;
            ex.a_data    <= preg[rs_preg];
            ex.b_data    <= (rn.req.op == rename_pkg::OP_LDI) ? imm_ext : preg[rt_preg];
        end
        if (alloc)
        begin
            al_old[al_tail] <= map_table[rn.req.rd];
        end
    end

    //////////////////////////////
    // Map, free list, active list
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NAREG; i++)
            begin
                map_table[i] <= `RN_PREG_W'(i);
            end
            for (int i = 0; i < NFREE; i++)
            begin
                free_list[i] <= `RN_PREG_W'(NAREG + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= (`RN_FREE_W+1)'(NFREE);
            al_head  <= '0;
            al_tail  <= '0;
            al_done  <= '0;
        end
        else
        begin
            if (alloc)
            begin
                map_table[rn.req.rd] <= free_list[fl_head];
                al_done[al_tail]     <= 1'b0;
                fl_head              <= fl_head + 1'b1;
                al_tail              <= al_tail + 1'b1;
            end
            if (wb_write)
            begin
                al_done[wb.slot] <= 1'b1;
            end
            // In-order retirement from the head
            if (retire)
            begin
                free_list[fl_tail] <= al_old[al_head];
                al_done[al_head]   <= 1'b0;
                fl_tail            <= fl_tail + 1'b1;
                al_head            <= al_head + 1'b1;
            end
            fl_count <= fl_count - (`RN_FREE_W+1)'(alloc) + (`RN_FREE_W+1)'(retire);
        end
    end

    // Physical registers and ready bits
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NPREG; i++)
            begin
                preg[i] <= '0;
            end
            preg_ready <= '1;
        end
        else
        begin
            if (alloc)
            begin
                preg_ready[free_list[fl_head]] <= 1'b0;
            end
            if (wb_write)
            begin
                preg[wb.preg]       <= wb.data;
                preg_ready[wb.preg] <= 1'b1;
            end
        end
    end

    a_free_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        fl_count <= NFREE
    ) else $error("free count above capacity");

    // Request is held through ack, so rd at ack is the allocating rd
    a_no_alloc_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        rn.ack && rn.req.rd != '0 |-> $past(fl_count) != '0
    ) else $error("allocation from empty free list");

    // A done head must belong to an allocated entry
    a_retire_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire |-> fl_count < NFREE
    ) else $error("retirement from an empty active list");

endmodule

//--- exec_stage.sv
`include "rename_params.svh"

module exec_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    exec_if.slave                 ex,
    writeback_if.master           wb,
    output logic                  result_valid,
    output logic [`RN_AREG_W-1:0] result_rd,
    output logic [`RN_DATA_W-1:0] result_data
);

    rename_pkg::exec_state_e state;
    rename_pkg::opcode_e     op_q;
    logic [`RN_AREG_W-1:0]   rd_q;
    logic [`RN_DATA_W-1:0]   a_q;
    logic [`RN_DATA_W-1:0]   b_q;
    logic [`RN_DATA_W-1:0]   alu;
    logic                    done;

    always_comb
    begin
        case (op_q)
            rename_pkg::OP_ADD: alu = a_q + b_q;
            rename_pkg::OP_SUB: alu = a_q - b_q;
            rename_pkg::OP_XOR: alu = a_q ^ b_q;
            default:            alu = b_q;
        endcase
    end

    // rd 0 finishes without a bus cycle
    assign done         = (state == rename_pkg::EX_WRITE) && (wb.ack || !wb.cyc);
    assign result_valid = done;
    assign result_rd    = rd_q;
    assign result_data  = wb.data;

    //////////////////////////////
    // Execute FSM
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state  <= rename_pkg::EX_IDLE;
            ex.ack <= 1'b0;
            wb.cyc <= 1'b0;
            wb.stb <= 1'b0;
        end
        else
        begin
            case (state)
                rename_pkg::EX_IDLE:
                begin
                    if (ex.cyc && ex.stb)
                    begin
                        ex.ack <= 1'b1;
                        state  <= rename_pkg::EX_EXEC;
                    end
                end
                rename_pkg::EX_EXEC:
                begin
                    ex.ack <= 1'b0;
                    if (rd_q != '0)
                    begin
                        wb.cyc <= 1'b1;
                        wb.stb <= 1'b1;
                    end
                    state <= rename_pkg::EX_WRITE;
                end
                rename_pkg::EX_WRITE:
                begin
                    if (done)
                    begin
                        wb.cyc <= 1'b0;
                        wb.stb <= 1'b0;
                        state  <= rename_pkg::EX_IDLE;
                    end
                end
                default:
                begin
                    state <= rename_pkg::EX_IDLE;
                end
            endcase
        end
    end

    // Operation capture and result register
    always_ff @(posedge clk)
    begin
        if (state == rename_pkg::EX_IDLE && ex.cyc && ex.stb)
        begin
            op_q    <= ex.op;
            rd_q    <= ex.arch_rd;
            a_q     <= ex.a_data;
            b_q     <= ex.b_data;
            wb.preg <= ex.dest_preg;
            wb.slot <= ex.slot;
        end
        if (state == rename_pkg::EX_EXEC)
        begin
            wb.data <= (rd_q != '0) ? alu : '0;
        end
    end

    a_wb_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb.stb && !wb.ack |=> wb.stb && $stable(wb.slot) && $stable(wb.data)
    ) else $error("writeback restarted before ack");

endmodule

//--- rename_core.sv
`include "rename_params.svh"

module rename_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid,
    input  logic [1:0]            instr_op,
    input  logic [`RN_AREG_W-1:0] instr_rd,
    input  logic [`RN_AREG_W-1:0] instr_rs,
    input  logic [`RN_AREG_W-1:0] instr_rt,
    input  logic [`RN_IMM_W-1:0]  instr_imm,
    output logic                  instr_ready,
    output logic                  result_valid,
    output logic [`RN_AREG_W-1:0] result_rd,
    output logic [`RN_DATA_W-1:0] result_data,
    output logic [`RN_FREE_W:0]   free_count
);

    rename_pkg::rename_req_t instr;

    rename_if    rn_bus ();
    exec_if      ex_bus ();
    writeback_if wb_bus ();

    // Pack the plain ports into a request
    assign instr.op  = rename_pkg::opcode_e'(instr_op);
    assign instr.rd  = instr_rd;
    assign instr.rs  = instr_rs;
    assign instr.rt  = instr_rt;
    assign instr.imm = instr_imm;

    issue_stage i_issue_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .rn          (rn_bus.master)
    );

    rename_unit i_rename_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .rn         (rn_bus.slave),
        .ex         (ex_bus.master),
        .wb         (wb_bus.slave),
        .free_count (free_count)
    );

    exec_stage i_exec_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex           (ex_bus.slave),
        .wb           (wb_bus.master),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data)
    );

endmodule

//--- tb_rename_core.sv
`include "rename_params.svh"

module tb_rename_core;

    localparam int DRIVE_DELAY  = 4;
    localparam int ACCEPT_LIMIT = 200;
    localparam int DRAIN_LIMIT  = 400;
    localparam int RANDOM_COUNT = 200;
    localparam logic [`RN_FREE_W:0] FULL_COUNT = (`RN_FREE_W+1)'(1 << `RN_FREE_W);

    logic                  clk;
    logic                  rst_n;
    logic                  instr_valid;
    logic [1:0]            instr_op;
    logic [`RN_AREG_W-1:0] instr_rd;
    logic [`RN_AREG_W-1:0] instr_rs;
    logic [`RN_AREG_W-1:0] instr_rt;
    logic [`RN_IMM_W-1:0]  instr_imm;
    logic                  instr_ready;
    logic                  result_valid;
    logic [`RN_AREG_W-1:0] result_rd;
    logic [`RN_DATA_W-1:0] result_data;
    logic [`RN_FREE_W:0]   free_count;

    // Reference register file and the expected results in order
    logic [`RN_DATA_W-1:0] model_regs [1 << `RN_AREG_W];
    logic [`RN_AREG_W-1:0] exp_rd_q [$];
    logic [`RN_DATA_W-1:0] exp_data_q [$];
    logic [`RN_AREG_W-1:0] head_rd;
    logic [`RN_DATA_W-1:0] head_data;
    int                    pending;
    logic                  idle_check;
    logic [31:0]           lcg_state;
    string                 test_name;

    rename_core i_rename_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr_op     (instr_op),
        .instr_rd     (instr_rd),
        .instr_rs     (instr_rs),
        .instr_rt     (instr_rt),
        .instr_imm    (instr_imm),
        .instr_ready  (instr_ready),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data),
        .free_count   (free_count)
    );

    always #20 clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [`RN_DATA_W-1:0] expected_value(input logic [1:0] op,
        input logic [`RN_DATA_W-1:0] a, input logic [`RN_DATA_W-1:0] b,
        input logic [`RN_IMM_W-1:0] imm);
        case (rename_pkg::opcode_e'(op))
            rename_pkg::OP_ADD: return a + b;
            rename_pkg::OP_SUB: return a - b;
            rename_pkg::OP_XOR: return a ^ b;
            default:            return {{(`RN_DATA_W - `RN_IMM_W){1'b0}}, imm};
        endcase
    endfunction

    task automatic report_value_error(input string what, input logic [31:0] exp,
        input logic [31:0] act);
        $display("ERR %s %s expected %0h actual %0h", test_name, what, exp, act);
        $display("TESTBENCH FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_failure(input string why);
        $display("%s during test %s", why, test_name);
        $display("TESTBENCH FAILED");
        $fatal(1, "run aborted");
    endtask

    // Reference update at the moment of acceptance
    function automatic void record_accept();
        logic [`RN_DATA_W-1:0] value;
        value = expected_value(instr_op, model_regs[instr_rs], model_regs[instr_rt], instr_imm);
        if (instr_rd == '0)
            value = '0;
        else
            model_regs[instr_rd] = value;
        exp_rd_q.push_back(instr_rd);
        exp_data_q.push_back(value);
    endfunction

    task automatic send_instr(input logic [1:0] op, input logic [`RN_AREG_W-1:0] rd,
        input logic [`RN_AREG_W-1:0] rs, input logic [`RN_AREG_W-1:0] rt,
        input logic [`RN_IMM_W-1:0] imm);
        int   waited;
        logic taken;
        instr_op    = op;
        instr_rd    = rd;
        instr_rs    = rs;
        instr_rt    = rt;
        instr_imm   = imm;
        instr_valid = 1'b1;
        waited      = 0;
        taken       = 1'b0;
        while (!taken && waited < ACCEPT_LIMIT)
        begin
            @(posedge clk);
            taken = instr_ready;
            #DRIVE_DELAY;
            waited++;
        end
        instr_valid = 1'b0;
        if (!taken)
            report_failure("instruction was never accepted");
    endtask

    // One cycle in which the idle assertions are armed
    task automatic check_idle();
        idle_check = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        idle_check = 1'b0;
    endtask

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        while (exp_data_q.size() != 0 && waited < DRAIN_LIMIT)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (exp_data_q.size() != 0)
            report_failure("results still pending after the drain timeout");
        waited = 0;
        while (free_count != FULL_COUNT && waited < DRAIN_LIMIT)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (free_count != FULL_COUNT)
            report_failure("free count did not return to full after drain");
        check_idle();
    endtask

    //////////////////////////////
    // Result tracking
    //////////////////////////////

    always @(posedge clk)
    begin
        if (rst_n && result_valid && exp_data_q.size() != 0)
        begin
            void'(exp_rd_q.pop_front());
            void'(exp_data_q.pop_front());
        end
        if (rst_n && instr_valid && instr_ready)
            record_accept();
        pending <= exp_data_q.size();
        if (exp_data_q.size() != 0)
        begin
            head_rd   <= exp_rd_q[0];
            head_data <= exp_data_q[0];
        end
    end

    a_result_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        result_valid |-> pending != 0
    ) else report_failure("result reported with no instruction pending");

    a_result_rd: assert property (
        @(posedge clk) disable iff (!rst_n)
        result_valid |-> result_rd == head_rd
    ) else report_value_error("result_rd", 32'($sampled(head_rd)), 32'($sampled(result_rd)));

    a_result_data: assert property (
        @(posedge clk) disable iff (!rst_n)
        result_valid |-> result_data == head_data
    ) else report_value_error("result_data", $sampled(head_data), $sampled(result_data));

    a_free_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        free_count <= FULL_COUNT
    ) else report_value_error("free_count bound", 32'(FULL_COUNT), 32'($sampled(free_count)));

    a_idle_free: assert property (
        @(posedge clk) disable iff (!rst_n)
        idle_check |-> free_count == FULL_COUNT
    ) else report_value_error("idle free_count", 32'(FULL_COUNT), 32'($sampled(free_count)));

    a_idle_quiet: assert property (
        @(posedge clk) disable iff (!rst_n)
        idle_check |-> !result_valid
    ) else report_value_error("idle result_valid", 32'd0, 32'd1);

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial
    begin
        int waited;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr_op    = '0;
        instr_rd    = '0;
        instr_rs    = '0;
        instr_rt    = '0;
        instr_imm   = '0;
        idle_check  = 1'b0;
        pending     = 0;
        head_rd     = '0;
        head_data   = '0;
        lcg_state   = 32'h7471_3019;
        test_name   = "reset";
        for (int i = 0; i < (1 << `RN_AREG_W); i++)
            model_regs[i] = '0;

        repeat (16) @(posedge clk);
        #DRIVE_DELAY;
        rst_n  = 1'b1;
        waited = 0;
        while (!instr_ready && waited < ACCEPT_LIMIT)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (!instr_ready)
            report_failure("instr_ready never rose after reset");
        check_idle();
        // Unwritten registers read zero
        send_instr(rename_pkg::OP_ADD, 3'd1, 3'd2, 3'd3, 16'h0000);
        drain_pipeline();

        test_name = "ldi_alu";
        send_instr(rename_pkg::OP_LDI, 3'd1, 3'd0, 3'd0, 16'h1234);
        send_instr(rename_pkg::OP_LDI, 3'd2, 3'd0, 3'd0, 16'hf00d);
        send_instr(rename_pkg::OP_LDI, 3'd3, 3'd0, 3'd0, 16'h0042);
        send_instr(rename_pkg::OP_LDI, 3'd4, 3'd0, 3'd0, 16'h0100);
        send_instr(rename_pkg::OP_ADD, 3'd5, 3'd1, 3'd2, 16'h0000);
        send_instr(rename_pkg::OP_SUB, 3'd6, 3'd3, 3'd4, 16'h0000);
        send_instr(rename_pkg::OP_XOR, 3'd7, 3'd5, 3'd6, 16'h0000);
        send_instr(rename_pkg::OP_SUB, 3'd1, 3'd2, 3'd1, 16'h0000);
        drain_pipeline();

        // Each one reads the previous destination
        test_name = "dependent";
        send_instr(rename_pkg::OP_LDI, 3'd2, 3'd0, 3'd0, 16'h0005);
        for (int i = 0; i < 6; i++)
            send_instr(rename_pkg::OP_ADD, 3'd2, 3'd2, 3'd2, 16'h0000);
        send_instr(rename_pkg::OP_SUB, 3'd3, 3'd2, 3'd1, 16'h0000);
        send_instr(rename_pkg::OP_XOR, 3'd3, 3'd3, 3'd2, 16'h0000);
        drain_pipeline();

        test_name = "reg_zero";
        send_instr(rename_pkg::OP_LDI, 3'd0, 3'd0, 3'd0, 16'hbeef);
        send_instr(rename_pkg::OP_ADD, 3'd0, 3'd1, 3'd2, 16'h0000);
        send_instr(rename_pkg::OP_ADD, 3'd4, 3'd0, 3'd0, 16'h0000);
        send_instr(rename_pkg::OP_XOR, 3'd5, 3'd0, 3'd1, 16'h0000);
        drain_pipeline();

        test_name = "random";
        for (int i = 0; i < RANDOM_COUNT; i++)
        begin
            lcg_state = lcg_next(lcg_state);
            send_instr(lcg_state[31:30], lcg_state[29:27], lcg_state[26:24],
                       lcg_state[23:21], lcg_state[20:5]);
            if (lcg_state[4])
            begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end

        test_name = "drain";
        drain_pipeline();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- build.f
+incdir+.
rename_pkg.sv
rename_ifs.sv
issue_stage.sv
rename_unit.sv
exec_stage.sv
rename_core.sv
tb_rename_core.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status carries the result
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f build.f \
        --top-module tb_rename_core -o tb_rename_core \
    && ./obj_dir/tb_rename_core \
    || { echo "simulation did not complete cleanly"; exit 1; }
